// File: rtl/cpu_pkg.sv
package cpu_pkg;

  localparam int XLEN          = 32;  // Register and data width
  localparam int AXI_ADDR_BITS = 32;
  localparam int AXI_DATA_BITS = 32;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;  // ADDI, ADD and SUB
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SB      = 3'b000;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_BASE    = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef logic [XLEN-1:0]            word_t;
  typedef logic [AXI_ADDR_BITS-1:0]   addr_t;
  typedef logic [AXI_DATA_BITS/8-1:0] strb_t;
  typedef logic [4:0]                 reg_idx_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    word_t instr;
  } fetch_to_exec_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     we;          // Register write-back enable
    word_t    alu_result;  // Also the load or store address
    word_t    store_data;  // Already shifted into its byte lanes
    strb_t    store_strb;
    logic     is_load;
    logic     is_store;
  } exec_to_mem_t;

  typedef struct packed {
    logic  re;
    logic  we;
    addr_t addr;
    word_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    WAIT_RESP
  } port_state_e;

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
  import cpu_pkg::*;
(
  input  logic           ACLK,
  input  logic           ARESETn,
  input  logic           stall,
  input  logic           fetch_done,
  input  word_t          fetch_word,
  input  logic           branch_taken,
  input  addr_t          branch_target,
  output addr_t          fetch_addr,
  output logic           fetch_en,
  output fetch_to_exec_t to_exec
);

  addr_t pc;

  assign fetch_addr = pc;  // The port latches this when it leaves IDLE

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      pc       <= '0;
      fetch_en <= 1'b0;
      to_exec  <= '0;
    end else begin
      fetch_en <= 1'b1;  // Fetch runs continuously once out of reset

      // A fetch that returns while the data port is busy is simply
      // repeated, since the PC does not move until the pipeline advances
      if (!stall && fetch_done) begin
        to_exec.valid <= !branch_taken;  // Squash the word behind a taken branch
        to_exec.pc    <= pc;
        to_exec.instr <= fetch_word;
        if (branch_taken) begin
          pc <= branch_target;
        end else begin
          pc <= pc + addr_t'(4);
        end
      end
    end
  end

endmodule

// File: rtl/decode_exec_stage.sv
`timescale 1ns/1ns

module decode_exec_stage
  import cpu_pkg::*;
(
  input  logic           ACLK,
  input  logic           ARESETn,
  input  logic           stall,
  input  fetch_to_exec_t from_fetch,
  input  logic           wb_en,
  input  reg_idx_t       wb_reg,
  input  word_t          wb_value,
  output exec_to_mem_t   to_mem,
  output logic           branch_taken,
  output addr_t          branch_target
);

  word_t      regs [32];
  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      load_addr;
  word_t      store_addr;
  logic       operands_equal;

  assign instr  = from_fetch.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // Register file written at the edge where the pipeline advances
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_reg != '0) begin
      regs[wb_reg] <= wb_value;
    end
  end

  // Operand read with bypass from the instruction writing back this cycle
  always_comb begin
    rs1_val = regs[rs1];
    if (rs1 == '0) begin
      rs1_val = '0;
    end else if (wb_en && wb_reg == rs1) begin
      rs1_val = wb_value;
    end
  end

  always_comb begin
    rs2_val = regs[rs2];
    if (rs2 == '0) begin
      rs2_val = '0;
    end else if (wb_en && wb_reg == rs2) begin
      rs2_val = wb_value;
    end
  end

  assign load_addr      = rs1_val + imm_i;  // Shared by ADDI and LW
  assign store_addr     = rs1_val + imm_s;
  assign operands_equal = (rs1_val == rs2_val);
  assign branch_target  = from_fetch.pc + imm_b;

  always_comb begin
    to_mem            = '0;
    to_mem.valid      = from_fetch.valid;
    to_mem.rd         = instr[11:7];
    to_mem.store_data = rs2_val;
    branch_taken      = 1'b0;

    case (opcode)
      OPC_OPIMM: begin
        if (funct3 == F3_ADD_SUB) begin
          to_mem.we         = from_fetch.valid;
          to_mem.alu_result = load_addr;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) begin
          to_mem.we         = from_fetch.valid;
          to_mem.alu_result = rs1_val + rs2_val;
        end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
          to_mem.we         = from_fetch.valid;
          to_mem.alu_result = rs1_val - rs2_val;
        end
      end
      OPC_LUI: begin
        to_mem.we         = from_fetch.valid;
        to_mem.alu_result = imm_u;
      end
      OPC_LOAD: begin
        if (funct3 == F3_LW) begin
          to_mem.we         = from_fetch.valid;
          to_mem.is_load    = from_fetch.valid;
          to_mem.alu_result = load_addr;
        end
      end
      OPC_STORE: begin
        to_mem.alu_result = store_addr;
        if (funct3 == F3_SW) begin
          to_mem.is_store   = from_fetch.valid;
          to_mem.store_strb = '1;
        end else if (funct3 == F3_SB) begin
          // Byte goes to the lane picked by the low address bits
          to_mem.is_store   = from_fetch.valid;
          to_mem.store_strb = strb_t'(1) << store_addr[1:0];
          to_mem.store_data = word_t'(rs2_val[7:0]) << {store_addr[1:0], 3'b000};
        end
      end
      OPC_BRANCH: begin
        if (funct3 == F3_BEQ) begin
          branch_taken = from_fetch.valid && !stall && operands_equal;
        end else if (funct3 == F3_BNE) begin
          branch_taken = from_fetch.valid && !stall && !operands_equal;
        end
      end
      default: begin
        to_mem.we = 1'b0;  // Anything outside the subset is a no-op
      end
    endcase
  end

endmodule

// File: rtl/mem_stage.sv
`timescale 1ns/1ns

module mem_stage
  import cpu_pkg::*;
(
  input  logic         ACLK,
  input  logic         ARESETn,
  input  logic         stall,
  input  exec_to_mem_t from_exec,
  input  word_t        load_data,
  output mem_req_t     mem_req,
  output logic         wb_en,
  output reg_idx_t     wb_reg,
  output word_t        wb_value
);

  exec_to_mem_t mem_q;
  logic         issue;  // High for the first cycle after a memory op enters

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      mem_q <= '0;
      issue <= 1'b0;
    end else begin
      issue <= 1'b0;
      if (!stall) begin
        mem_q <= from_exec;
        issue <= from_exec.is_load || from_exec.is_store;
      end
    end
  end

  // One request per memory instruction held for a single cycle
  always_comb begin
    mem_req.re    = issue && mem_q.is_load;
    mem_req.we    = issue && mem_q.is_store;
    mem_req.addr  = mem_q.alu_result;
    mem_req.wdata = mem_q.store_data;
    mem_req.strb  = mem_q.store_strb;
  end

  // Write-back lands on the same edge that moves the pipeline
  assign wb_en    = mem_q.valid && mem_q.we && !stall;
  assign wb_reg   = mem_q.rd;
  assign wb_value = mem_q.is_load ? load_data : mem_q.alu_result;

endmodule

// File: rtl/axi_imem_port.sv
`timescale 1ns/1ns

module axi_imem_port
  import cpu_pkg::*;
(
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  logic                     fetch_en,
  input  addr_t                    fetch_addr,
  output logic                     fetch_done,
  output word_t                    fetch_word,

  output logic [AXI_ADDR_BITS-1:0] ARADDR_M0,
  output logic                     ARVALID_M0,
  input  logic                     ARREADY_M0,
  input  logic [AXI_DATA_BITS-1:0] RDATA_M0,
  input  logic                     RVALID_M0,
  output logic                     RREADY_M0
);

  port_state_e state;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state      <= IDLE;
      ARVALID_M0 <= 1'b0;
      RREADY_M0  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (fetch_en) begin
            ARVALID_M0 <= 1'b1;
            state      <= ADDR;
          end
        end
        ADDR: begin
          if (ARREADY_M0) begin
            ARVALID_M0 <= 1'b0;
            RREADY_M0  <= 1'b1;  // Ready only while a response is owed
            state      <= WAIT_RESP;
          end
        end
        WAIT_RESP: begin
          if (RVALID_M0) begin
            RREADY_M0 <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address is sampled once per request and held until ARREADY
  always_ff @(posedge ACLK) begin
    if (state == IDLE && fetch_en) begin
      ARADDR_M0 <= fetch_addr;
    end
  end

  assign fetch_done = RVALID_M0 && RREADY_M0;
  assign fetch_word = RDATA_M0;  // Taken by the fetch stage on fetch_done

endmodule

// File: rtl/axi_dmem_port.sv
`timescale 1ns/1ns

module axi_dmem_port
  import cpu_pkg::*;
(
  input  logic                       ACLK,
  input  logic                       ARESETn,
  input  mem_req_t                   mem_req,
  output logic                       busy,
  output word_t                      load_data,

  output logic [AXI_ADDR_BITS-1:0]   ARADDR_M1,
  output logic                       ARVALID_M1,
  input  logic                       ARREADY_M1,
  input  logic [AXI_DATA_BITS-1:0]   RDATA_M1,
  input  logic                       RVALID_M1,
  output logic                       RREADY_M1,
  output logic [AXI_ADDR_BITS-1:0]   AWADDR_M1,
  output logic                       AWVALID_M1,
  input  logic                       AWREADY_M1,
  output logic [AXI_DATA_BITS-1:0]   WDATA_M1,
  output logic [AXI_DATA_BITS/8-1:0] WSTRB_M1,
  output logic                       WVALID_M1,
  input  logic                       WREADY_M1,
  input  logic                       BVALID_M1,
  output logic                       BREADY_M1
);

  port_state_e state;
  logic        op_write;    // Current access is a store
  logic        aw_pending;  // AW still owed after this cycle
  logic        w_pending;   // W still owed after this cycle

  assign aw_pending = AWVALID_M1 && !AWREADY_M1;
  assign w_pending  = WVALID_M1 && !WREADY_M1;

  // A request counts as busy in the very cycle it shows up
  assign busy = (state != IDLE) || mem_req.re || mem_req.we;

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state      <= IDLE;
      op_write   <= 1'b0;
      ARVALID_M1 <= 1'b0;
      RREADY_M1  <= 1'b0;
      AWVALID_M1 <= 1'b0;
      WVALID_M1  <= 1'b0;
      BREADY_M1  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (mem_req.we) begin
            op_write   <= 1'b1;
            AWVALID_M1 <= 1'b1;  // AW and W launch together
            WVALID_M1  <= 1'b1;
            state      <= ADDR;
          end else if (mem_req.re) begin
            op_write   <= 1'b0;
            ARVALID_M1 <= 1'b1;
            state      <= ADDR;
          end
        end
        ADDR: begin
          if (op_write) begin
            AWVALID_M1 <= aw_pending;
            WVALID_M1  <= w_pending;
            if (!aw_pending && !w_pending) begin
              BREADY_M1 <= 1'b1;
              state     <= WAIT_RESP;
            end
          end else if (ARREADY_M1) begin
            ARVALID_M1 <= 1'b0;
            RREADY_M1  <= 1'b1;
            state      <= WAIT_RESP;
          end
        end
        WAIT_RESP: begin
          if (op_write) begin
            if (BVALID_M1 && BREADY_M1) begin
              BREADY_M1 <= 1'b0;  // Store is done only on the B handshake
              state     <= IDLE;
            end
          end else if (RVALID_M1 && RREADY_M1) begin
            RREADY_M1 <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, data and strobes stay put for the whole access
  always_ff @(posedge ACLK) begin
    if (state == IDLE && (mem_req.re || mem_req.we)) begin
      ARADDR_M1 <= mem_req.addr;
      AWADDR_M1 <= mem_req.addr;
      WDATA_M1  <= mem_req.wdata;
      WSTRB_M1  <= mem_req.strb;
    end
    if (RVALID_M1 && RREADY_M1) begin
      load_data <= RDATA_M1;
    end
  end

endmodule

// File: rtl/axi_cpu_wrapper.sv
`timescale 1ns/1ns

module axi_cpu_wrapper
  import cpu_pkg::*;
(
  input  logic                       ACLK,
  input  logic                       ARESETn,

  // Master 0 instruction fetch
  output logic [AXI_ADDR_BITS-1:0]   ARADDR_M0,
  output logic                       ARVALID_M0,
  input  logic                       ARREADY_M0,
  input  logic [AXI_DATA_BITS-1:0]   RDATA_M0,
  input  logic [1:0]                 RRESP_M0,  // Response codes are accepted but not checked
  input  logic                       RVALID_M0,
  output logic                       RREADY_M0,

  // Master 1 data loads and stores
  output logic [AXI_ADDR_BITS-1:0]   ARADDR_M1,
  output logic                       ARVALID_M1,
  input  logic                       ARREADY_M1,
  input  logic [AXI_DATA_BITS-1:0]   RDATA_M1,
  input  logic [1:0]                 RRESP_M1,
  input  logic                       RVALID_M1,
  output logic                       RREADY_M1,
  output logic [AXI_ADDR_BITS-1:0]   AWADDR_M1,
  output logic                       AWVALID_M1,
  input  logic                       AWREADY_M1,
  output logic [AXI_DATA_BITS-1:0]   WDATA_M1,
  output logic [AXI_DATA_BITS/8-1:0] WSTRB_M1,
  output logic                       WVALID_M1,
  input  logic                       WREADY_M1,
  input  logic [1:0]                 BRESP_M1,
  input  logic                       BVALID_M1,
  output logic                       BREADY_M1
);

  logic           stall;
  logic           fetch_en;
  addr_t          fetch_addr;
  logic           fetch_done;
  word_t          fetch_word;
  logic           branch_taken;
  addr_t          branch_target;
  fetch_to_exec_t fetch_to_exec;
  exec_to_mem_t   exec_to_mem;
  logic           wb_en;
  reg_idx_t       wb_reg;
  word_t          wb_value;
  mem_req_t       mem_req;
  word_t          load_data;
  logic           dmem_busy;

  // Advance only on a fetch response with the data port free
  assign stall = !fetch_done || dmem_busy;

  fetch_stage i_fetch_stage (
    .ACLK,
    .ARESETn,
    .stall,
    .fetch_done,
    .fetch_word,
    .branch_taken,
    .branch_target,
    .fetch_addr,
    .fetch_en,
    .to_exec       (fetch_to_exec)
  );

  decode_exec_stage i_decode_exec_stage (
    .ACLK,
    .ARESETn,
    .stall,
    .from_fetch    (fetch_to_exec),
    .wb_en,
    .wb_reg,
    .wb_value,
    .to_mem        (exec_to_mem),
    .branch_taken,
    .branch_target
  );

  mem_stage i_mem_stage (
    .ACLK,
    .ARESETn,
    .stall,
    .from_exec     (exec_to_mem),
    .load_data,
    .mem_req,
    .wb_en,
    .wb_reg,
    .wb_value
  );

  axi_imem_port i_axi_imem_port (
    .ACLK,
    .ARESETn,
    .fetch_en,
    .fetch_addr,
    .fetch_done,
    .fetch_word,
    .ARADDR_M0,
    .ARVALID_M0,
    .ARREADY_M0,
    .RDATA_M0,
    .RVALID_M0,
    .RREADY_M0
  );

  axi_dmem_port i_axi_dmem_port (
    .ACLK,
    .ARESETn,
    .mem_req,
    .busy          (dmem_busy),
    .load_data,
    .ARADDR_M1,
    .ARVALID_M1,
    .ARREADY_M1,
    .RDATA_M1,
    .RVALID_M1,
    .RREADY_M1,
    .AWADDR_M1,
    .AWVALID_M1,
    .AWREADY_M1,
    .WDATA_M1,
    .WSTRB_M1,
    .WVALID_M1,
    .WREADY_M1,
    .BVALID_M1,
    .BREADY_M1
  );

endmodule

// File: testbench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int    PROG_LEN   = 60;
localparam int    LAST_IDX   = PROG_LEN - 1;  // Slot of the closing BEQ x0,x0,0
localparam int    DATA_WORDS = 64;            // 256-byte data window
localparam addr_t DATA_BASE  = 32'h0000_1000;

word_t prog [PROG_LEN];
addr_t exp_ld_addr [$];
addr_t exp_st_addr [$];
word_t exp_st_data [$];
strb_t exp_st_strb [$];

// Initial data memory contents that mix in every address bit
function automatic word_t fill_word(addr_t a);
  return (a * 32'h9E37_79B9) ^ {a[15:0], ~a[15:0]};
endfunction

function automatic int rand_below(int n);
  int r;
  r = $random(seed);
  return (r & 32'h7fff_ffff) % n;
endfunction

// x31 holds the data window base and is never written afterwards
task automatic gen_program();
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [11:0] imm;
  logic [12:0] off;
  int          k;
  prog[0] = {20'h00001, 5'd31, OPC_LUI};
  for (int i = 1; i < LAST_IDX; i++) begin
    rd  = reg_idx_t'(1 + rand_below(7));
    rs1 = reg_idx_t'(rand_below(8));
    rs2 = reg_idx_t'(rand_below(8));
    imm = 12'($random(seed));
    case (rand_below(8))
      0: prog[i] = {imm, rs1, F3_ADD_SUB, rd, OPC_OPIMM};
      1: prog[i] = {F7_BASE, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
      2: prog[i] = {F7_SUB, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
      3: prog[i] = {imm, 8'($random(seed)), rd, OPC_LUI};
      4: begin
        imm     = 12'(rand_below(64) * 4);
        prog[i] = {imm, 5'd31, F3_LW, rd, OPC_LOAD};
      end
      5: begin
        imm     = 12'(rand_below(64) * 4);
        prog[i] = {imm[11:5], rs2, 5'd31, F3_SW, imm[4:0], OPC_STORE};
      end
      6: begin
        imm     = 12'(rand_below(256));  // Any byte lane
        prog[i] = {imm[11:5], rs2, 5'd31, F3_SB, imm[4:0], OPC_STORE};
      end
      default: begin
        k = 1 + rand_below(4);  // Forward only and never past the end
        if (i + k > LAST_IDX) begin
          k = LAST_IDX - i;
        end
        off     = 13'(k * 4);
        prog[i] = {off[12], off[10:5], rs2, rs1, (rand_below(2) == 0) ? F3_BEQ : F3_BNE,
                   off[4:1], off[11], OPC_BRANCH};
      end
    endcase
  end
  prog[LAST_IDX] = {7'b0, 5'd0, 5'd0, F3_BEQ, 5'b0, OPC_BRANCH};
endtask

// Instruction-set model that fills the expected load and store lists
task automatic run_model();
  word_t      regs [32];
  word_t      mem [DATA_WORDS];
  word_t      ins;
  word_t      a;
  word_t      b;
  word_t      ea;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  logic [6:0] opc;
  logic [2:0] f3;
  int         idx;
  int         w;
  int         lane;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  for (int i = 0; i < DATA_WORDS; i++) begin
    mem[i] = fill_word(DATA_BASE + addr_t'(4 * i));
  end
  idx = 0;
  while (idx != LAST_IDX) begin
    ins   = prog[idx];
    opc   = ins[6:0];
    f3    = ins[14:12];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    idx   = idx + 1;
    case (opc)
      OPC_OPIMM: regs[ins[11:7]] = a + imm_i;
      OPC_OP:    regs[ins[11:7]] = ins[30] ? a - b : a + b;
      OPC_LUI:   regs[ins[11:7]] = {ins[31:12], 12'b0};
      OPC_LOAD: begin
        ea = a + imm_i;
        exp_ld_addr.push_back(ea);
        regs[ins[11:7]] = mem[int'((ea - DATA_BASE) >> 2)];
      end
      OPC_STORE: begin
        ea   = a + imm_s;
        w    = int'((ea - DATA_BASE) >> 2);
        lane = int'(ea[1:0]);
        exp_st_addr.push_back(ea);
        if (f3 == F3_SW) begin
          exp_st_data.push_back(b);
          exp_st_strb.push_back(4'hF);
          mem[w] = b;
        end else begin
          exp_st_data.push_back(word_t'(b[7:0]) << (8 * lane));
          exp_st_strb.push_back(strb_t'(1) << lane);
          mem[w][8*lane +: 8] = b[7:0];
        end
      end
      OPC_BRANCH: begin
        if ((f3 == F3_BEQ) == (a == b)) begin
          idx = idx - 1 + int'(imm_b >> 2);
        end
      end
      default: ;
    endcase
    regs[0] = '0;
  end
endtask

`endif

// File: testbench/tb_axi_cpu_wrapper.sv
`timescale 1ns/1ns

module tb_axi_cpu_wrapper
  import cpu_pkg::*;
();

  localparam int CLK_PERIOD = 8;

  logic        ACLK;
  logic        ARESETn;
  addr_t       ARADDR_M0;
  logic        ARVALID_M0;
  logic        ARREADY_M0;
  word_t       RDATA_M0;
  logic [1:0]  RRESP_M0;
  logic        RVALID_M0;
  logic        RREADY_M0;
  addr_t       ARADDR_M1;
  logic        ARVALID_M1;
  logic        ARREADY_M1;
  word_t       RDATA_M1;
  logic [1:0]  RRESP_M1;
  logic        RVALID_M1;
  logic        RREADY_M1;
  addr_t       AWADDR_M1;
  logic        AWVALID_M1;
  logic        AWREADY_M1;
  word_t       WDATA_M1;
  strb_t       WSTRB_M1;
  logic        WVALID_M1;
  logic        WREADY_M1;
  logic [1:0]  BRESP_M1;
  logic        BVALID_M1;
  logic        BREADY_M1;

  integer seed = 32'h0794_6346;

  `include "tb_ref_model.svh"

  word_t dmem [DATA_WORDS];
  int    ld_idx;
  int    st_idx;
  int    spin_count;
  int    spin_start;

  // Slave bookkeeping
  int    ar0_wait;
  int    r0_wait;
  int    ar1_wait;
  int    r1_wait;
  int    aw_wait;
  int    w_wait;
  int    b_wait;
  logic  rd0_pend;
  logic  rd1_pend;
  logic  aw_got;
  logic  w_got;
  logic  b_pend;
  addr_t rd0_addr;
  addr_t rd1_addr;
  addr_t aw_addr_q;
  word_t w_data_q;
  strb_t w_strb_q;

  // Protocol monitor state
  logic  ar0_hold;
  logic  ar1_hold;
  logic  aw_hold;
  logic  w_hold;
  addr_t ar0_addr_h;
  addr_t ar1_addr_h;
  addr_t aw_addr_h;
  word_t w_data_h;
  strb_t w_strb_h;
  int    m0_open;
  int    m1_open;

  axi_cpu_wrapper i_axi_cpu_wrapper (.*);

  task automatic check(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  function automatic word_t imem_word(addr_t a);
    if ((a >> 2) < PROG_LEN) begin
      return prog[a >> 2];
    end
    return '0;
  endfunction

  initial begin
    ACLK = 1'b0;
    forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
  end

  // Master 0 slave serving the instruction memory
  always @(posedge ACLK) begin
    if (!ARESETn) begin
      ARREADY_M0 <= 1'b0;
      RVALID_M0  <= 1'b0;
      rd0_pend   <= 1'b0;
      ar0_wait   <= 0;
      r0_wait    <= 0;
    end else begin
      ARREADY_M0 <= 1'b0;
      if (ARVALID_M0 && ARREADY_M0) begin
        rd0_pend <= 1'b1;
        rd0_addr <= ARADDR_M0;
        ar0_wait <= rand_below(4);
        r0_wait  <= rand_below(4);
        if (ARADDR_M0 == addr_t'(LAST_IDX * 4)) begin
          spin_count++;
        end
      end else if (ARVALID_M0 && !rd0_pend) begin
        if (ar0_wait == 0) ARREADY_M0 <= 1'b1;
        else ar0_wait <= ar0_wait - 1;
      end
      if (rd0_pend && !RVALID_M0) begin
        if (r0_wait == 0) begin
          RVALID_M0 <= 1'b1;
          RDATA_M0  <= imem_word(rd0_addr);
        end else begin
          r0_wait <= r0_wait - 1;
        end
      end
      if (RVALID_M0 && RREADY_M0) begin
        RVALID_M0 <= 1'b0;
        rd0_pend  <= 1'b0;
      end
    end
  end

  // Master 1 slave serving the data memory and checking loads and stores
  always @(posedge ACLK) begin
    if (!ARESETn) begin
      ARREADY_M1 <= 1'b0;
      RVALID_M1  <= 1'b0;
      AWREADY_M1 <= 1'b0;
      WREADY_M1  <= 1'b0;
      BVALID_M1  <= 1'b0;
      rd1_pend   <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
      b_pend     <= 1'b0;
      ar1_wait   <= 0;
      r1_wait    <= 0;
      aw_wait    <= 0;
      w_wait     <= 0;
      b_wait     <= 0;
    end else begin
      ARREADY_M1 <= 1'b0;
      AWREADY_M1 <= 1'b0;
      WREADY_M1  <= 1'b0;
      if (ARVALID_M1 && ARREADY_M1) begin
        check(ld_idx < exp_ld_addr.size(), 1, "load beyond the expected count");
        check(ARADDR_M1, exp_ld_addr[ld_idx], "load address");
        ld_idx++;
        rd1_pend <= 1'b1;
        rd1_addr <= ARADDR_M1;
        ar1_wait <= rand_below(4);
        r1_wait  <= rand_below(4);
      end else if (ARVALID_M1 && !rd1_pend) begin
        if (ar1_wait == 0) ARREADY_M1 <= 1'b1;
        else ar1_wait <= ar1_wait - 1;
      end
      if (rd1_pend && !RVALID_M1) begin
        if (r1_wait == 0) begin
          RVALID_M1 <= 1'b1;
          RDATA_M1  <= dmem[int'((rd1_addr - DATA_BASE) >> 2)];
        end else begin
          r1_wait <= r1_wait - 1;
        end
      end
      if (RVALID_M1 && RREADY_M1) begin
        RVALID_M1 <= 1'b0;
        rd1_pend  <= 1'b0;
      end

      if (AWVALID_M1 && AWREADY_M1) begin
        aw_got    <= 1'b1;
        aw_addr_q <= AWADDR_M1;
        aw_wait   <= rand_below(4);
      end else if (AWVALID_M1 && !aw_got && !b_pend) begin
        if (aw_wait == 0) AWREADY_M1 <= 1'b1;
        else aw_wait <= aw_wait - 1;
      end
      if (WVALID_M1 && WREADY_M1) begin
        w_got    <= 1'b1;
        w_data_q <= WDATA_M1;
        w_strb_q <= WSTRB_M1;
        w_wait   <= rand_below(4);
      end else if (WVALID_M1 && !w_got && !b_pend) begin
        if (w_wait == 0) WREADY_M1 <= 1'b1;
        else w_wait <= w_wait - 1;
      end

      // Both halves of the store are in, so compare and commit
      if (aw_got && w_got) begin
        check(st_idx < exp_st_addr.size(), 1, "store beyond the expected count");
        check(aw_addr_q, exp_st_addr[st_idx], "store address");
        if (exp_st_strb[st_idx] != 4'hF) begin
          check($countones(w_strb_q), 1, "SB strobe count");
          check(word_t'(w_strb_q), word_t'(4'b1 << aw_addr_q[1:0]), "SB byte lane");
        end
        check(w_data_q, exp_st_data[st_idx], "store data");
        check(word_t'(w_strb_q), word_t'(exp_st_strb[st_idx]), "store strobes");
        for (int i = 0; i < 4; i++) begin
          if (w_strb_q[i]) begin
            dmem[int'((aw_addr_q - DATA_BASE) >> 2)][8*i +: 8] = w_data_q[8*i +: 8];
          end
        end
        st_idx++;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_pend <= 1'b1;
        b_wait <= rand_below(4);
      end
      if (b_pend && !BVALID_M1) begin
        if (b_wait == 0) BVALID_M1 <= 1'b1;
        else b_wait <= b_wait - 1;
      end
      if (BVALID_M1 && BREADY_M1) begin
        BVALID_M1 <= 1'b0;
        b_pend    <= 1'b0;
      end
    end
  end

  // Valid stays up with a stable payload and only one transaction is open at a time
  always @(posedge ACLK) begin
    if (ARESETn) begin
      if (ar0_hold) begin
        check(ARVALID_M0, 1, "ARVALID_M0 dropped before ARREADY_M0");
        check(ARADDR_M0, ar0_addr_h, "ARADDR_M0 changed while waiting");
      end
      if (ar1_hold) begin
        check(ARVALID_M1, 1, "ARVALID_M1 dropped before ARREADY_M1");
        check(ARADDR_M1, ar1_addr_h, "ARADDR_M1 changed while waiting");
      end
      if (aw_hold) begin
        check(AWVALID_M1, 1, "AWVALID_M1 dropped before AWREADY_M1");
        check(AWADDR_M1, aw_addr_h, "AWADDR_M1 changed while waiting");
      end
      if (w_hold) begin
        check(WVALID_M1, 1, "WVALID_M1 dropped before WREADY_M1");
        check(WDATA_M1, w_data_h, "WDATA_M1 changed while waiting");
        check(word_t'(WSTRB_M1), word_t'(w_strb_h), "WSTRB_M1 changed while waiting");
      end
      if (ARVALID_M0 && !ar0_hold) begin
        check(m0_open, 0, "fetch issued before the previous response");
      end
      if ((ARVALID_M1 && !ar1_hold) || (AWVALID_M1 && !aw_hold)) begin
        check(m1_open, 0, "data request issued before the previous response");
      end
      m0_open += int'(ARVALID_M0 && ARREADY_M0) - int'(RVALID_M0 && RREADY_M0);
      m1_open += int'(ARVALID_M1 && ARREADY_M1) + int'(AWVALID_M1 && AWREADY_M1)
               - int'(RVALID_M1 && RREADY_M1) - int'(BVALID_M1 && BREADY_M1);
    end
    ar0_hold   = ARVALID_M0 && !ARREADY_M0;
    ar1_hold   = ARVALID_M1 && !ARREADY_M1;
    aw_hold    = AWVALID_M1 && !AWREADY_M1;
    w_hold     = WVALID_M1 && !WREADY_M1;
    ar0_addr_h = ARADDR_M0;
    ar1_addr_h = ARADDR_M1;
    aw_addr_h  = AWADDR_M1;
    w_data_h   = WDATA_M1;
    w_strb_h   = WSTRB_M1;
  end

  initial begin
    #(PROG_LEN * 200 * CLK_PERIOD);
    $display("Timeout: the program did not reach its final branch in time");
    $display("Result: FAILED");
    $fatal(1);
  end

  initial begin
    ARESETn    = 1'b0;
    ARREADY_M0 = 1'b0;
    RDATA_M0   = '0;
    RRESP_M0   = AXI_RESP_OKAY;
    RVALID_M0  = 1'b0;
    ARREADY_M1 = 1'b0;
    RDATA_M1   = '0;
    RRESP_M1   = AXI_RESP_OKAY;
    RVALID_M1  = 1'b0;
    AWREADY_M1 = 1'b0;
    WREADY_M1  = 1'b0;
    BRESP_M1   = AXI_RESP_OKAY;
    BVALID_M1  = 1'b0;
    ld_idx     = 0;
    st_idx     = 0;
    spin_count = 0;
    m0_open    = 0;
    m1_open    = 0;
    gen_program();
    run_model();
    for (int i = 0; i < DATA_WORDS; i++) begin
      dmem[i] = fill_word(DATA_BASE + addr_t'(4 * i));
    end
    repeat (2) @(posedge ACLK);
    ARESETn <= 1'b1;
    while (st_idx < exp_st_addr.size()) @(posedge ACLK);
    spin_start = spin_count;  // Then wait for the core to loop on the last BEQ
    while (spin_count < spin_start + 4) @(posedge ACLK);
    if (st_idx == exp_st_addr.size() && ld_idx == exp_ld_addr.size()) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Load or store count differs from the model at the end of the program");
      $display("Result: FAILED");
      $fatal(1);
    end
  end

endmodule

// File: build.f
+incdir+testbench
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_exec_stage.sv
rtl/mem_stage.sv
rtl/axi_imem_port.sv
rtl/axi_dmem_port.sv
rtl/axi_cpu_wrapper.sv
testbench/tb_axi_cpu_wrapper.sv
